// ==== src/core_pkg.sv ====
package core_pkg;

  // ========================================
  // Widths
  // ========================================
  localparam int DATA_WIDTH    = 32;
  localparam int REG_COUNT     = 32;
  localparam int REG_IDX_WIDTH = 5;

  typedef logic [DATA_WIDTH-1:0]    word_t;
  typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

  // ========================================
  // Encodings
  // ========================================
  localparam logic [6:0] OPC_REG = 7'b0110011;
  localparam logic [6:0] OPC_IMM = 7'b0010011;

  localparam logic [2:0] FN3_ADD = 3'b000;
  localparam logic [2:0] FN3_SLL = 3'b001;
  localparam logic [2:0] FN3_XOR = 3'b100;
  localparam logic [2:0] FN3_SRL = 3'b101;
  localparam logic [2:0] FN3_OR  = 3'b110;
  localparam logic [2:0] FN3_AND = 3'b111;

  localparam logic [6:0] FN7_BASE   = 7'b0000000;
  localparam logic [6:0] FN7_ALT    = 7'b0100000;
  localparam logic [6:0] FN7_MULDIV = 7'b0000001;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL
  } alu_op_t;

  // Same 32 bits, two field layouts
  typedef struct packed {
    logic [6:0]  funct7;
    reg_idx_t    rs2;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } reg_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } imm_fmt_t;

  typedef union packed {
    reg_fmt_t reg_view;
    imm_fmt_t imm_view;
  } instr_u;

endpackage

// ==== src/instr_decode.sv ====
module instr_decode import core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     instr_valid_i,
  input  instr_u   instr_i,
  input  word_t    rs1_data_i,
  input  word_t    rs2_data_i,
  output reg_idx_t rs1_idx_o,
  output reg_idx_t rs2_idx_o,
  output logic     alu_issue_o,
  output alu_op_t  alu_op_o,
  output word_t    alu_a_o,
  output word_t    alu_b_o,
  output reg_idx_t alu_rd_o,
  output logic     mul_issue_o,
  output word_t    mul_a_o,
  output word_t    mul_b_o,
  output reg_idx_t mul_rd_o
);

  logic     is_alu;
  logic     is_mul;
  alu_op_t  op_d;
  word_t    b_d;
  reg_idx_t rd_d;

  // rs1 sits at the same bits in both forms
  assign rs1_idx_o = instr_i.reg_view.rs1;
  assign rs2_idx_o = instr_i.reg_view.rs2;

  always_comb begin
    is_alu = 1'b0;
    is_mul = 1'b0;
    op_d   = ALU_ADD;
    b_d    = rs2_data_i;
    rd_d   = instr_i.reg_view.rd;

    case (instr_i.reg_view.opcode)
      OPC_REG: begin
        is_alu = 1'b1;
        case ({instr_i.reg_view.funct7, instr_i.reg_view.funct3})
          {FN7_BASE, FN3_ADD}: op_d = ALU_ADD;
          {FN7_ALT, FN3_ADD}:  op_d = ALU_SUB;
          {FN7_BASE, FN3_SLL}: op_d = ALU_SLL;
          {FN7_BASE, FN3_XOR}: op_d = ALU_XOR;
          {FN7_BASE, FN3_SRL}: op_d = ALU_SRL;
          {FN7_BASE, FN3_OR}:  op_d = ALU_OR;
          {FN7_BASE, FN3_AND}: op_d = ALU_AND;
          {FN7_MULDIV, FN3_ADD}: begin
            is_alu = 1'b0;
            is_mul = 1'b1;
          end
          default: is_alu = 1'b0;
        endcase
      end
      OPC_IMM: begin
        is_alu = 1'b1;
        b_d    = {{(DATA_WIDTH-12){instr_i.imm_view.imm12[11]}}, instr_i.imm_view.imm12};
        case (instr_i.imm_view.funct3)
          FN3_ADD: op_d = ALU_ADD;
          FN3_XOR: op_d = ALU_XOR;
          FN3_OR:  op_d = ALU_OR;
          FN3_AND: op_d = ALU_AND;
          default: is_alu = 1'b0;
        endcase
      end
      default: ;
    endcase
  end

  // ========================================
  // Issue registers
  // ========================================
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      alu_issue_o <= 1'b0;
      mul_issue_o <= 1'b0;
    end else begin
      alu_issue_o <= instr_valid_i & is_alu;
      mul_issue_o <= instr_valid_i & is_mul;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i && is_alu) begin
      alu_op_o <= op_d;
      alu_a_o  <= rs1_data_i;
      alu_b_o  <= b_d;
      alu_rd_o <= rd_d;
    end
    if (instr_valid_i && is_mul) begin
      mul_a_o  <= rs1_data_i;
      mul_b_o  <= rs2_data_i;
      mul_rd_o <= rd_d;
    end
  end

endmodule

// ==== src/alu_execute.sv ====
module alu_execute import core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     alu_issue_i,
  input  alu_op_t  alu_op_i,
  input  word_t    alu_a_i,
  input  word_t    alu_b_i,
  input  reg_idx_t alu_rd_i,
  output logic     wb_valid_o,
  output reg_idx_t wb_rd_o,
  output word_t    wb_data_o
);

  logic [4:0] shamt;
  word_t      result;

  // Only the low five bits shift
  assign shamt = alu_b_i[4:0];

  always_comb begin
    case (alu_op_i)
      ALU_ADD: result = alu_a_i + alu_b_i;
      ALU_SUB: result = alu_a_i - alu_b_i;
      ALU_AND: result = alu_a_i & alu_b_i;
      ALU_OR:  result = alu_a_i | alu_b_i;
      ALU_XOR: result = alu_a_i ^ alu_b_i;
      ALU_SLL: result = alu_a_i << shamt;
      ALU_SRL: result = alu_a_i >> shamt;
      default: result = '0;
    endcase
  end

  // ========================================
  // Retire register
  // ========================================
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= alu_issue_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alu_issue_i) begin
      wb_rd_o   <= alu_rd_i;
      wb_data_o <= result;
    end
  end

endmodule

// ==== src/mul_pipeline.sv ====
module mul_pipeline import core_pkg::*; #(
  parameter int MUL_STAGES = 5
)(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     mul_issue_i,
  input  word_t    mul_a_i,
  input  word_t    mul_b_i,
  input  reg_idx_t mul_rd_i,
  output logic     wb_valid_o,
  output reg_idx_t wb_rd_o,
  output word_t    wb_data_o
);

  logic     valid_q [MUL_STAGES];
  reg_idx_t rd_q    [MUL_STAGES];
  word_t    prod_q  [MUL_STAGES];
  word_t    product;

  // Low half of the product only
  assign product = mul_a_i * mul_b_i;

  // ========================================
  // Valid chain
  // ========================================
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < MUL_STAGES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else begin
      valid_q[0] <= mul_issue_i;
      for (int i = 1; i < MUL_STAGES; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // ========================================
  // Payload chain
  // ========================================
  always_ff @(posedge clk_i) begin
    rd_q[0]   <= mul_rd_i;
    prod_q[0] <= product;
    for (int i = 1; i < MUL_STAGES; i++) begin
      rd_q[i]   <= rd_q[i-1];
      prod_q[i] <= prod_q[i-1];
    end
  end

  assign wb_valid_o = valid_q[MUL_STAGES-1];
  assign wb_rd_o    = rd_q[MUL_STAGES-1];
  assign wb_data_o  = prod_q[MUL_STAGES-1];

endmodule

// ==== src/result_writeback.sv ====
module result_writeback import core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     alu_wb_valid_i,
  input  reg_idx_t alu_wb_rd_i,
  input  word_t    alu_wb_data_i,
  input  logic     mul_wb_valid_i,
  input  reg_idx_t mul_wb_rd_i,
  input  word_t    mul_wb_data_i,
  input  reg_idx_t rs1_idx_i,
  input  reg_idx_t rs2_idx_i,
  output word_t    rs1_data_o,
  output word_t    rs2_data_o
);

  word_t regs_q [REG_COUNT];

  logic alu_we;
  logic mul_we;

  // x0 is hardwired
  assign alu_we = alu_wb_valid_i && (alu_wb_rd_i != '0);
  assign mul_we = mul_wb_valid_i && (mul_wb_rd_i != '0);

  // ========================================
  // Write ports
  // ========================================
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      if (mul_we) begin
        regs_q[mul_wb_rd_i] <= mul_wb_data_i;
      end
      // Younger ALU result overrides a same-edge multiply
      if (alu_we) begin
        regs_q[alu_wb_rd_i] <= alu_wb_data_i;
      end
    end
  end

  // ========================================
  // Read ports
  // ========================================
  assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs_q[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs_q[rs2_idx_i];

endmodule

// ==== src/int_core.sv ====
module int_core import core_pkg::*; #(
  parameter int MUL_STAGES = 5
)(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     instr_valid_i,
  input  instr_u   instr_i,
  output logic     alu_wb_valid_o,
  output reg_idx_t alu_wb_rd_o,
  output word_t    alu_wb_data_o,
  output logic     mul_wb_valid_o,
  output reg_idx_t mul_wb_rd_o,
  output word_t    mul_wb_data_o
);

  // Operand read
  reg_idx_t rs1_idx, rs2_idx;
  word_t    rs1_data, rs2_data;

  // Issue to ALU
  logic     alu_issue;
  alu_op_t  alu_op;
  word_t    alu_a, alu_b;
  reg_idx_t alu_rd;

  // Issue to multiplier
  logic     mul_issue;
  word_t    mul_a, mul_b;
  reg_idx_t mul_rd;

  instr_decode u_decode (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .rs1_idx_o     (rs1_idx),
    .rs2_idx_o     (rs2_idx),
    .alu_issue_o   (alu_issue),
    .alu_op_o      (alu_op),
    .alu_a_o       (alu_a),
    .alu_b_o       (alu_b),
    .alu_rd_o      (alu_rd),
    .mul_issue_o   (mul_issue),
    .mul_a_o       (mul_a),
    .mul_b_o       (mul_b),
    .mul_rd_o      (mul_rd)
  );

  alu_execute u_alu (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .alu_issue_i (alu_issue),
    .alu_op_i    (alu_op),
    .alu_a_i     (alu_a),
    .alu_b_i     (alu_b),
    .alu_rd_i    (alu_rd),
    .wb_valid_o  (alu_wb_valid_o),
    .wb_rd_o     (alu_wb_rd_o),
    .wb_data_o   (alu_wb_data_o)
  );

  mul_pipeline #(
    .MUL_STAGES (MUL_STAGES)
  ) u_mul (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mul_issue_i (mul_issue),
    .mul_a_i     (mul_a),
    .mul_b_i     (mul_b),
    .mul_rd_i    (mul_rd),
    .wb_valid_o  (mul_wb_valid_o),
    .wb_rd_o     (mul_wb_rd_o),
    .wb_data_o   (mul_wb_data_o)
  );

  result_writeback u_result (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .alu_wb_valid_i (alu_wb_valid_o),
    .alu_wb_rd_i    (alu_wb_rd_o),
    .alu_wb_data_i  (alu_wb_data_o),
    .mul_wb_valid_i (mul_wb_valid_o),
    .mul_wb_rd_i    (mul_wb_rd_o),
    .mul_wb_data_i  (mul_wb_data_o),
    .rs1_idx_i      (rs1_idx),
    .rs2_idx_i      (rs2_idx),
    .rs1_data_o     (rs1_data),
    .rs2_data_o     (rs2_data)
  );

endmodule

// ==== verif/tb_int_core.sv ====
module tb_int_core import core_pkg::*; ();

  localparam int MUL_STAGES = 5;
  localparam int MAX_CASES  = 64;

  logic     clk;
  logic     rst;
  logic     instr_valid;
  instr_u   instr;
  logic     alu_wb_valid;
  reg_idx_t alu_wb_rd;
  word_t    alu_wb_data;
  logic     mul_wb_valid;
  reg_idx_t mul_wb_rd;
  word_t    mul_wb_data;

  // Case table loaded from the data file
  int       gap_a  [MAX_CASES];
  word_t    word_a [MAX_CASES];
  byte      unit_a [MAX_CASES];
  reg_idx_t rd_a   [MAX_CASES];
  word_t    exp_a  [MAX_CASES];
  int       n_cases = 0;

  // Outstanding results per retire port
  reg_idx_t alu_rd_q[$];
  word_t    alu_data_q[$];
  reg_idx_t mul_rd_q[$];
  word_t    mul_data_q[$];

  int cycles      = 0;
  int cycle_limit = 0;

  int_core #(
    .MUL_STAGES (MUL_STAGES)
  ) UUT (
    .clk_i          (clk),
    .rst_i          (rst),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .alu_wb_valid_o (alu_wb_valid),
    .alu_wb_rd_o    (alu_wb_rd),
    .alu_wb_data_o  (alu_wb_data),
    .mul_wb_valid_o (mul_wb_valid),
    .mul_wb_rd_o    (mul_wb_rd),
    .mul_wb_data_o  (mul_wb_data)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Run did not finish within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  // ========================================
  // Result checks
  // ========================================
  task automatic check_alu_result(input reg_idx_t rd, input word_t data);
    reg_idx_t exp_rd;
    word_t    exp_data;
    if (alu_rd_q.size() == 0) begin
      $display("ALU port retired rd %0d while no ALU result was expected", rd);
      $display("TB FAILED");
      $fatal(1, "unexpected ALU retire");
    end else begin
      exp_rd   = alu_rd_q.pop_front();
      exp_data = alu_data_q.pop_front();
      if (rd !== exp_rd || data !== exp_data) begin
        $display("** Error at %0t: ALU retire rd %0d data %h, expected rd %0d data %h",
                 $time, rd, data, exp_rd, exp_data);
        $display("TB FAILED");
        $fatal(1, "ALU result mismatch");
      end
    end
  endtask

  task automatic check_mul_result(input reg_idx_t rd, input word_t data);
    reg_idx_t exp_rd;
    word_t    exp_data;
    if (mul_rd_q.size() == 0) begin
      $display("Multiply port retired rd %0d while no product was expected", rd);
      $display("TB FAILED");
      $fatal(1, "unexpected multiply retire");
    end else begin
      exp_rd   = mul_rd_q.pop_front();
      exp_data = mul_data_q.pop_front();
      if (rd !== exp_rd || data !== exp_data) begin
        $display("** Error at %0t: MUL retire rd %0d data %h, expected rd %0d data %h",
                 $time, rd, data, exp_rd, exp_data);
        $display("TB FAILED");
        $fatal(1, "multiply result mismatch");
      end
    end
  endtask

  // Sample away from the driving edge
  always @(negedge clk) begin
    if (rst && alu_wb_valid) begin
      check_alu_result(alu_wb_rd, alu_wb_data);
    end
    if (rst && mul_wb_valid) begin
      check_mul_result(mul_wb_rd, mul_wb_data);
    end
  end

  task automatic load_cases();
    int    fd;
    string line;
    int    gap;
    word_t w;
    byte   u;
    int    rd;
    word_t e;
    fd = $fopen("verif/int_core_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open verif/int_core_cases.txt");
      $display("TB FAILED");
      $fatal(1, "missing cases file");
    end else begin
      while ($fgets(line, fd) > 0) begin
        // Comment and blank lines do not scan
        if ($sscanf(line, "%d %h %c %d %h", gap, w, u, rd, e) == 5 && n_cases < MAX_CASES) begin
          gap_a[n_cases]  = gap;
          word_a[n_cases] = w;
          unit_a[n_cases] = u;
          rd_a[n_cases]   = reg_idx_t'(rd);
          exp_a[n_cases]  = e;
          n_cases++;
        end
      end
      $fclose(fd);
    end
  endtask

  // ========================================
  // Stimulus
  // ========================================
  initial begin
    int total_gap;
    rst         = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    total_gap   = 0;
    load_cases();
    for (int i = 0; i < n_cases; i++) begin
      total_gap += gap_a[i];
    end
    cycle_limit = total_gap + n_cases + MUL_STAGES + 20;

    repeat (3) @(posedge clk);
    rst <= 1'b1;

    for (int i = 0; i < n_cases; i++) begin
      repeat (gap_a[i]) begin
        instr_valid <= 1'b0;
        @(posedge clk);
      end
      instr_valid <= 1'b1;
      instr       <= word_a[i];
      if (unit_a[i] == "A") begin
        alu_rd_q.push_back(rd_a[i]);
        alu_data_q.push_back(exp_a[i]);
      end else if (unit_a[i] == "M") begin
        mul_rd_q.push_back(rd_a[i]);
        mul_data_q.push_back(exp_a[i]);
      end
      @(posedge clk);
    end
    instr_valid <= 1'b0;

    // Let the multiply pipeline drain
    repeat (MUL_STAGES + 3) @(posedge clk);

    if (alu_rd_q.size() != 0 || mul_rd_q.size() != 0) begin
      $display("Results never retired: %0d on the ALU port, %0d on the multiply port",
               alu_rd_q.size(), mul_rd_q.size());
      $display("TB FAILED");
      $fatal(1, "missing retires");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// ==== project.f ====
src/core_pkg.sv
src/instr_decode.sv
src/alu_execute.sv
src/mul_pipeline.sv
src/result_writeback.sv
src/int_core.sv
verif/tb_int_core.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_int_core -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_int_core > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0

// ==== verif/int_core_cases.txt ====
# gap(idle cycles, dec)  word(hex)  unit(A=ALU M=MUL N=none)  rd(dec)  expected(hex)
# Register init via immediates, then register forms, immediates, multiplies, conflict, bad words
2 12300093 A 1 00000123
0 FFB00113 A 2 FFFFFFFB
0 7FF00193 A 3 000007FF
0 02400213 A 4 00000024
2 002082B3 A 5 0000011E
0 40308333 A 6 FFFFF924
0 003173B3 A 7 000007FB
0 0040E433 A 8 00000127
0 0030C4B3 A 9 000006DC
0 00409533 A 10 00001230
0 004155B3 A 11 0FFFFFFF
0 0F017613 A 12 000000F0
0 F000E693 A 13 FFFFFF23
0 FFF1C713 A 14 FFFFF800
0 00508013 A 0 00000128
0 023087B3 M 15 000916DD
0 02310833 M 16 FFFFD805
0 022088B3 M 17 FFFFFA51
0 02408933 M 18 000028EC
3 00418933 A 18 00000823
2 000909B3 A 19 00000823
0 00078A33 A 20 000916DD
0 00400AB3 A 21 00000024
0 FFFFFFFF N 0 00000000
0 4020C433 N 0 00000000
0 00109413 N 0 00000000
